// ==== skinny_core.f ====
+incdir+include
hw/skinny_pkg.sv
hw/skinny_sbox8.sv
hw/skinny_round.sv
hw/skinny_tweakey.sv
hw/skinny_ctrl.sv
hw/skinny_core.sv
sim/skinny_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SKINNY core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
   --top-module skinny_core_tb \
   -f skinny_core.f \
   --Mdir obj_dir \
   -o skinny_core_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/skinny_core_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation ended with status $status"
   exit $status
fi

exit 0

// ==== include/skinny_ref.svh ====
`ifndef SKINNY_REF_SVH
`define SKINNY_REF_SVH

// New cell i comes from old cell SR_SRC[i]
localparam int SR_SRC [16] = '{0, 1, 2, 3, 7, 4, 5, 6, 10, 11, 8, 9, 13, 14, 15, 12};
localparam int TK_SRC [16] = '{9, 15, 8, 13, 10, 14, 12, 11, 0, 1, 2, 3, 4, 5, 6, 7};

// One NOR stage on bits 0 and 4
function automatic cell_t nor_mix(cell_t v);
   cell_t r;
   r = v;
   r[0] = v[0] ^ ~(v[3] | v[2]);
   r[4] = v[4] ^ ~(v[7] | v[6]);
   return r;
endfunction

// Wiring between NOR stages
function automatic cell_t bit_permute(cell_t v);
   return {v[2], v[1], v[7], v[6], v[4], v[0], v[3], v[5]};
endfunction

function automatic cell_t sub_cell(cell_t x);
   cell_t v;
   int    k;
   v = x;
   for (k = 0; k < 3; k++) begin
      v = bit_permute(nor_mix(v));
   end
   v = nor_mix(v);
   return {v[7:3], v[1], v[2], v[0]};  // Last stage swaps bits 1 and 2
endfunction

function automatic cell_t lfsr2(cell_t c);
   return {c[6:0], c[7] ^ c[5]};
endfunction

function automatic cell_t lfsr3(cell_t c);
   return {c[0] ^ c[6], c[7:1]};
endfunction

function automatic rc_t step_constant(rc_t rc);
   return {rc[4:0], ~(rc[5] ^ rc[4])};
endfunction

function automatic block_t encrypt_block(block_t pt, block_t k1, block_t k2, block_t k3,
                                         int rounds);
   cell_t  s  [NUM_CELLS];
   cell_t  t  [NUM_CELLS];
   cell_t  t1 [NUM_CELLS];
   cell_t  t2 [NUM_CELLS];
   cell_t  t3 [NUM_CELLS];
   cell_t  n1 [NUM_CELLS];
   cell_t  n2 [NUM_CELLS];
   cell_t  n3 [NUM_CELLS];
   block_t ct;
   rc_t    rc;
   int     r;
   int     i;
   for (i = 0; i < NUM_CELLS; i++) begin
      s[i]  = pt[127-8*i -: 8];
      t1[i] = k1[127-8*i -: 8];
      t2[i] = k2[127-8*i -: 8];
      t3[i] = k3[127-8*i -: 8];
   end
   rc = RC_INIT;
   for (r = 0; r < rounds; r++) begin
      for (i = 0; i < NUM_CELLS; i++) begin
         s[i] = sub_cell(s[i]);
      end
      s[0] = s[0] ^ {4'h0, rc[3:0]};
      s[4] = s[4] ^ {6'h0, rc[5:4]};
      s[8] = s[8] ^ 8'h02;
      for (i = 0; i < 8; i++) begin
         s[i] = s[i] ^ t1[i] ^ t2[i] ^ t3[i];  // Rows 0 and 1 only
      end
      for (i = 0; i < NUM_CELLS; i++) begin
         t[i] = s[SR_SRC[i]];
      end
      // Column mixing
      for (i = 0; i < 4; i++) begin
         s[i]      = t[i] ^ t[8+i] ^ t[12+i];
         s[4+i]    = t[i];
         s[8+i]    = t[4+i] ^ t[8+i];
         s[12+i]   = t[i] ^ t[8+i];
      end
      for (i = 0; i < NUM_CELLS; i++) begin
         n1[i] = t1[TK_SRC[i]];
         n2[i] = t2[TK_SRC[i]];
         n3[i] = t3[TK_SRC[i]];
      end
      for (i = 0; i < NUM_CELLS; i++) begin
         t1[i] = n1[i];
         t2[i] = (i < 8) ? lfsr2(n2[i]) : n2[i];
         t3[i] = (i < 8) ? lfsr3(n3[i]) : n3[i];
      end
      rc = step_constant(rc);
   end
   for (i = 0; i < NUM_CELLS; i++) begin
      ct[127-8*i -: 8] = s[i];
   end
   return ct;
endfunction

`endif

// ==== sim/skinny_core_tb.sv ====
`timescale 1ns/1ps

module skinny_core_tb;
   import skinny_pkg::*;

   localparam int NUM_ROUNDS   = DEFAULT_ROUNDS;
   localparam int RESET_CYCLES = 8;
   localparam int NUM_RANDOM   = 40;
   localparam int NUM_ENC      = NUM_RANDOM + 5;
   localparam int SLACK_CYCLES = 40;  // Idle checks after reset and at the end
   localparam int LIMIT_CYCLES = RESET_CYCLES + NUM_ENC * (NUM_ROUNDS + 4) + SLACK_CYCLES;

   logic        clk;
   logic        rst;
   logic        start;
   block_t      plaintext;
   block_t      tk1;
   block_t      tk2;
   block_t      tk3;
   block_t      ciphertext;
   logic        busy;
   logic        done;
   block_t      expected [$];
   block_t      last_result;
   logic        have_result;
   int          done_count;
   logic [31:0] lfsr_state;

   `include "skinny_ref.svh"

   skinny_core #(
      .NUM_ROUNDS (NUM_ROUNDS)
   ) skinny_core_i (
      .clk        (clk),
      .rst        (rst),
      .start      (start),
      .plaintext  (plaintext),
      .tk1        (tk1),
      .tk2        (tk2),
      .tk3        (tk3),
      .ciphertext (ciphertext),
      .busy       (busy),
      .done       (done)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   task automatic stop_with_failure(string what);
      $display("%s", what);
      $display("Regression failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_block(string name, block_t exp, block_t act);
      if (act !== exp) begin
         stop_with_failure($sformatf("error %s expected %h actual %h", name, exp, act));
      end
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      if (act !== exp) begin
         stop_with_failure($sformatf("error %s expected %h actual %h", name, exp, act));
      end
   endtask

   // Galois form with taps 32 22 2 1
   function automatic logic [31:0] next_lfsr(logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   function automatic block_t random_block();
      block_t b;
      int     k;
      b = '0;
      for (k = 0; k < 128; k++) begin
         b = {b[126:0], lfsr_state[0]};
         lfsr_state = next_lfsr(lfsr_state);
      end
      return b;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic launch(block_t p, block_t a, block_t b, block_t c);
      start     = 1'b1;
      plaintext = p;
      tk1       = a;
      tk2       = b;
      tk3       = c;
      expected.push_back(encrypt_block(p, a, b, c, NUM_ROUNDS));
      next_cycle();
      start = 1'b0;
      check_bit("busy", 1'b1, busy);
   endtask

   task automatic wait_done();
      while (!done) begin
         next_cycle();
      end
   endtask

   task automatic run_one(block_t p, block_t a, block_t b, block_t c);
      launch(p, a, b, c);
      wait_done();
      repeat (2) next_cycle();
   endtask

   // Result check at done and hold check while idle
   initial begin : compare
      block_t exp;
      done_count  = 0;
      have_result = 1'b0;
      forever begin
         @(negedge clk);
         if (!rst && done) begin
            if (expected.size() == 0) begin
               stop_with_failure("done pulsed with no encryption pending");
            end else begin
               exp = expected.pop_front();
               check_block("ciphertext", exp, ciphertext);
               check_bit("busy", 1'b0, busy);
               last_result = exp;
               have_result = 1'b1;
               done_count++;
            end
         end else if (!rst && !busy && have_result) begin
            check_block("ciphertext", last_result, ciphertext);
         end
      end
   end

   initial begin : watchdog
      #(LIMIT_CYCLES * 10);
      stop_with_failure("timeout, done never arrived within the expected time");
   end

   initial begin : stimulus
      block_t p;
      block_t a;
      block_t b;
      block_t c;
      int     n;
      int     i;
      rst        = 1'b1;
      start      = 1'b0;
      plaintext  = '0;
      tk1        = '0;
      tk2        = '0;
      tk3        = '0;
      lfsr_state = 32'd69;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst = 1'b0;
      for (i = 0; i < 10; i++) begin
         check_bit("busy", 1'b0, busy);
         check_bit("done", 1'b0, done);
         next_cycle();
      end
      run_one('0, '0, '0, '0);
      run_one('1, '1, '1, '1);
      for (i = 0; i < NUM_RANDOM; i++) begin
         p = random_block();
         a = random_block();
         b = random_block();
         c = random_block();
         run_one(p, a, b, c);
      end
      // Second start while busy must be dropped
      n = done_count;
      p = random_block();
      a = random_block();
      b = random_block();
      c = random_block();
      launch(p, a, b, c);
      repeat (5) next_cycle();
      start     = 1'b1;
      plaintext = ~p;
      tk1       = ~a;
      tk2       = ~b;
      tk3       = ~c;
      next_cycle();
      start = 1'b0;
      wait_done();
      repeat (4) next_cycle();
      if (done_count != n + 1) begin
         stop_with_failure("start while busy changed the number of done pulses");
      end
      // Restart in the done cycle
      launch(random_block(), random_block(), random_block(), random_block());
      wait_done();
      launch(random_block(), random_block(), random_block(), random_block());
      wait_done();
      repeat (4) next_cycle();
      if (expected.size() != 0) begin
         stop_with_failure("encryptions still pending at the end of the run");
      end else begin
         $display("Regression passed");
         $finish;
      end
   end

endmodule

// ==== hw/skinny_core.sv ====
`timescale 1ns/1ps

module skinny_core #(
   parameter int NUM_ROUNDS = skinny_pkg::DEFAULT_ROUNDS
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               start,
   input  skinny_pkg::block_t plaintext,
   input  skinny_pkg::block_t tk1,
   input  skinny_pkg::block_t tk2,
   input  skinny_pkg::block_t tk3,
   output skinny_pkg::block_t ciphertext,
   output logic               busy,
   output logic               done
);
   import skinny_pkg::*;

   logic  load;
   logic  step;
   rc_t   rc;
   half_t rk1;
   half_t rk2;
   half_t rk3;

   skinny_ctrl #(
      .NUM_ROUNDS (NUM_ROUNDS)
   ) ctrl_i (
      .clk   (clk),
      .rst   (rst),
      .start (start),
      .load  (load),
      .step  (step),
      .rc    (rc),
      .busy  (busy),
      .done  (done)
   );

   skinny_round round_i (
      .clk       (clk),
      .rst       (rst),
      .load      (load),
      .step      (step),
      .plaintext (plaintext),
      .rk1       (rk1),
      .rk2       (rk2),
      .rk3       (rk3),
      .rc        (rc),
      .state     (ciphertext)  // Held after the last round
   );

   skinny_tweakey #(.TK_LFSR(TK_LFSR_NONE)) tk1_i (
      .clk (clk), .rst (rst), .load (load), .step (step),
      .tk_in   (tk1),
      .rk_half (rk1)
   );

   skinny_tweakey #(.TK_LFSR(TK_LFSR2)) tk2_i (
      .clk (clk), .rst (rst), .load (load), .step (step),
      .tk_in   (tk2),
      .rk_half (rk2)
   );

   skinny_tweakey #(.TK_LFSR(TK_LFSR3)) tk3_i (
      .clk (clk), .rst (rst), .load (load), .step (step),
      .tk_in   (tk3),
      .rk_half (rk3)
   );

endmodule

// ==== hw/skinny_ctrl.sv ====
`timescale 1ns/1ps

module skinny_ctrl #(
   parameter int NUM_ROUNDS = skinny_pkg::DEFAULT_ROUNDS
) (
   input  logic            clk,
   input  logic            rst,
   input  logic            start,
   output logic            load,
   output logic            step,
   output skinny_pkg::rc_t rc,
   output logic            busy,
   output logic            done
);
   import skinny_pkg::*;

   round_cnt_t cnt;  // Rounds already done
   logic       last;

   assign load = start & ~busy;  // Start ignored while running
   assign step = busy;
   assign last = (cnt == round_cnt_t'(NUM_ROUNDS - 1));

   always_ff @(posedge clk) begin
      if (rst) begin
         busy <= 1'b0;
         done <= 1'b0;
         cnt  <= '0;
         rc   <= '0;
      end else begin
         done <= 1'b0;
         if (load) begin
            busy <= 1'b1;
            cnt  <= '0;
            rc   <= RC_INIT;
         end else if (step) begin
            cnt <= cnt + 1'b1;
            rc  <= rc_next(rc);
            // Final round on this edge
            if (last) begin
               busy <= 1'b0;
               done <= 1'b1;
            end
         end
      end
   end

endmodule

// ==== hw/skinny_tweakey.sv ====
`timescale 1ns/1ps

module skinny_tweakey #(
   parameter skinny_pkg::tk_lfsr_e TK_LFSR = skinny_pkg::TK_LFSR_NONE
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               load,
   input  logic               step,
   input  skinny_pkg::block_t tk_in,
   output skinny_pkg::half_t  rk_half
);
   import skinny_pkg::*;

   // New cell i is taken from old cell PT[i]
   localparam int PT [NUM_CELLS] = '{9, 15, 8, 13, 10, 14, 12, 11, 0, 1, 2, 3, 4, 5, 6, 7};

   block_t tk;
   block_t tk_perm;
   block_t tk_next;

   function automatic cell_t lane_lfsr(cell_t c);
      case (TK_LFSR)
         TK_LFSR2: return {c[6:0], c[7] ^ c[5]};
         TK_LFSR3: return {c[0] ^ c[6], c[7:1]};
         default:  return c;  // TK1 only permutes
      endcase
   endfunction

   genvar i;

   for (i = 0; i < NUM_CELLS; i = i + 1) begin : g_perm
      assign tk_perm[127-8*i -: 8] = tk[127-8*PT[i] -: 8];
   end

   // LFSR only on the half that feeds the round
   for (i = 0; i < NUM_CELLS / 2; i = i + 1) begin : g_lfsr
      assign tk_next[127-8*i -: 8] = lane_lfsr(tk_perm[127-8*i -: 8]);
   end

   assign tk_next[63:0] = tk_perm[63:0];

   always_ff @(posedge clk) begin
      if (rst) begin
         tk <= '0;
      end else if (load) begin
         tk <= tk_in;
      end else if (step) begin
         tk <= tk_next;
      end
   end

   assign rk_half = tk[127:64];

endmodule

// ==== hw/skinny_round.sv ====
`timescale 1ns/1ps

module skinny_round (
   input  logic               clk,
   input  logic               rst,
   input  logic               load,
   input  logic               step,
   input  skinny_pkg::block_t plaintext,
   input  skinny_pkg::half_t  rk1,
   input  skinny_pkg::half_t  rk2,
   input  skinny_pkg::half_t  rk3,
   input  skinny_pkg::rc_t    rc,
   output skinny_pkg::block_t state
);
   import skinny_pkg::*;

   block_t      sb;
   block_t      atk;
   block_t      nxt;
   logic [31:0] a0;
   logic [31:0] a1;
   logic [31:0] a2;
   logic [31:0] a3;
   logic [31:0] s0;
   logic [31:0] s1;
   logic [31:0] s2;
   logic [31:0] s3;
   logic [31:0] m0;
   logic [31:0] m1;
   logic [31:0] m2;
   logic [31:0] m3;

   genvar i;

   for (i = 0; i < NUM_CELLS; i = i + 1) begin : g_sbox
      skinny_sbox8 sbox_i (
         .si (state[127-8*i -: 8]),
         .so (sb[127-8*i -: 8])
      );
   end

   // Round tweakey on rows 0 and 1 and then the constants
   assign atk = sb ^ {rk1 ^ rk2 ^ rk3, 64'h0} ^ rc_word(rc);

   assign a0 = atk[127:96];
   assign a1 = atk[95:64];
   assign a2 = atk[63:32];
   assign a3 = atk[31:0];

   // ShiftRows rotates row r right by r cells
   assign s0 = a0;
   assign s1 = {a1[7:0], a1[31:8]};
   assign s2 = {a2[15:0], a2[31:16]};
   assign s3 = {a3[23:0], a3[31:24]};

   // MixColumns
   assign m1 = s0;
   assign m2 = s1 ^ s2;
   assign m3 = s0 ^ s2;
   assign m0 = s3 ^ m3;

   assign nxt = {m0, m1, m2, m3};

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= '0;
      end else if (load) begin
         state <= plaintext;
      end else if (step) begin
         state <= nxt;
      end
   end

endmodule

// ==== hw/skinny_sbox8.sv ====
`timescale 1ns/1ps

module skinny_sbox8 (
   input  skinny_pkg::cell_t si,
   output skinny_pkg::cell_t so
);

   logic [7:0] a;

   // Basic stage (x nor y) xor z
   function automatic logic nx(logic x, logic y, logic z);
      return ~(x | y) ^ z;
   endfunction

   // Eight chained stages
   assign a[0] = nx(si[7], si[6], si[4]);
   assign a[1] = nx(si[3], si[2], si[0]);
   assign a[2] = nx(si[2], si[1], si[6]);
   assign a[3] = nx(a[0],  a[1],  si[5]);
   assign a[4] = nx(a[1],  si[3], si[1]);
   assign a[5] = nx(a[2],  a[3],  si[7]);
   assign a[6] = nx(a[3],  a[0],  si[3]);
   assign a[7] = nx(a[4],  a[5],  si[2]);

   // Final bit reordering
   assign so = {a[3], a[0], a[1], a[6], a[4], a[2], a[5], a[7]};

endmodule

// ==== hw/skinny_pkg.sv ====
package skinny_pkg;

   // Cell 0 is the most significant byte of a block
   typedef logic [127:0] block_t;
   typedef logic [63:0]  half_t;  // Rows 0 and 1 of a tweakey word
   typedef logic [7:0]   cell_t;
   typedef logic [5:0]   rc_t;
   typedef logic [7:0]   round_cnt_t;

   // Update applied to the upper half of a tweakey lane
   typedef enum logic [1:0] {
      TK_LFSR_NONE,
      TK_LFSR2,
      TK_LFSR3
   } tk_lfsr_e;

   localparam int NUM_CELLS = 16;

   localparam rc_t RC_INIT = 6'h01;  // Constant of the first round

   // SKINNY-128-384
   localparam int DEFAULT_ROUNDS = 56;

   // Round constant LFSR shifts left and feeds back ~(b5 ^ b4)
   function automatic rc_t rc_next(rc_t rc);
      return {rc[4:0], ~(rc[5] ^ rc[4])};
   endfunction

   // Constant word added after the S-box layer
   function automatic block_t rc_word(rc_t rc);
      block_t w;
      w = '0;
      w[123:120] = rc[3:0];  // Cell 0
      w[89:88]   = rc[5:4];  // Cell 4
      w[57]      = 1'b1;     // Cell 8 gets 0x02
      return w;
   endfunction

endpackage
